//--- rtl/rvPkg.sv
package rvPkg;

	localparam int XLEN = 32; // data and instruction width
	localparam int REG_NUM_W = 5;
	localparam int MEM_WORDS = 1024;
	localparam int MEM_ADDR_W = $clog2(MEM_WORDS); // word index

	// major opcodes handled by the core
	typedef enum logic [6:0]
	{
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_LUI    = 7'b0110111
	} opcode_t;

	typedef enum logic [3:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT, // signed
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA, // arithmetic
		ALU_OR,
		ALU_AND
	} aluOp_t;

	// execution class carried from decode into execute
	typedef enum logic [1:0]
	{
		EX_IDLE,
		EX_REG_WRITE,
		EX_MEM_READ_REG_WRITE,
		EX_MEM_WRITE
	} execKind_t;

endpackage

//--- rtl/alu.sv
module alu (
	input  logic [rvPkg::XLEN-1:0]   a_i,
	input  logic [rvPkg::XLEN-1:0]   b_i,
	input  rvPkg::aluOp_t            op_i,
	output logic [rvPkg::XLEN-1:0]   result_o
);

	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb
	begin
		case (op_i)
			rvPkg::ALU_ADD:  result_o = a_i + b_i;
			rvPkg::ALU_SUB:  result_o = a_i - b_i;
			rvPkg::ALU_SLL:  result_o = a_i << shamt;
			rvPkg::ALU_SLT:  result_o = {{(rvPkg::XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
			rvPkg::ALU_SLTU: result_o = {{(rvPkg::XLEN-1){1'b0}}, a_i < b_i};
			rvPkg::ALU_XOR:  result_o = a_i ^ b_i;
			rvPkg::ALU_SRL:  result_o = a_i >> shamt;
			rvPkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt; // keeps sign
			rvPkg::ALU_OR:   result_o = a_i | b_i;
			rvPkg::ALU_AND:  result_o = a_i & b_i;
			default:         result_o = '0;
		endcase
	end

endmodule

//--- rtl/dataMem.sv
module dataMem #(
	parameter int DEPTH = 1024,
	parameter int ADDR_W = 10,
	parameter int DATA_W = 32
) (
	input  logic                clk,
	input  logic [ADDR_W-1:0]   addr_i,
	input  logic                writeEn_i,
	input  logic [DATA_W-1:0]   writeData_i,
	output logic [DATA_W-1:0]   readData_o
);

	logic [DATA_W-1:0] mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (writeEn_i)
			mem[addr_i] <= writeData_i;
	end

	assign readData_o = mem[addr_i]; // async read

endmodule

//--- rtl/regFile.sv
module regFile (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [rvPkg::REG_NUM_W-1:0]   rs1_i,
	input  logic [rvPkg::REG_NUM_W-1:0]   rs2_i,
	output logic [rvPkg::XLEN-1:0]        rs1Data_o,
	output logic [rvPkg::XLEN-1:0]        rs2Data_o,
	input  logic                          writeEn_i,
	input  logic [rvPkg::REG_NUM_W-1:0]   writeNum_i,
	input  logic [rvPkg::XLEN-1:0]        writeData_i,
	input  logic [rvPkg::REG_NUM_W-1:0]   watchNum_i,
	output logic [rvPkg::XLEN-1:0]        watchData_o
);

	localparam int NUM_REGS = 1 << rvPkg::REG_NUM_W;

	logic [rvPkg::XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (writeEn_i)
			regs[writeNum_i] <= writeData_i; // x0 never arrives
	end

	assign rs1Data_o = regs[rs1_i];
	assign rs2Data_o = regs[rs2_i];
	assign watchData_o = regs[watchNum_i]; // debug view

	noWriteToZero: assert property (@(posedge clk) disable iff (reset)
		writeEn_i |-> writeNum_i != '0)
		else $error("register zero written");

endmodule

//--- rtl/instrDecoder.sv
module instrDecoder (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          instrValid_i,
	input  logic [rvPkg::XLEN-1:0]        instr_i,
	output rvPkg::execKind_t              kind_o,
	output rvPkg::aluOp_t                 aluOp_o,
	output logic [rvPkg::REG_NUM_W-1:0]   rs1_o,
	output logic [rvPkg::REG_NUM_W-1:0]   rs2_o,
	output logic [rvPkg::REG_NUM_W-1:0]   rd_o,
	output logic [rvPkg::XLEN-1:0]        imm_o,
	output logic                          useImm_o
);

	rvPkg::opcode_t                opcode;
	logic [2:0]                    funct3;
	logic [rvPkg::REG_NUM_W-1:0]   rd;
	logic [rvPkg::XLEN-1:0]        immI, immS, immU;
	rvPkg::execKind_t              kindNext;
	rvPkg::aluOp_t                 aluOpNext;
	logic [rvPkg::REG_NUM_W-1:0]   rs1Next;
	logic [rvPkg::XLEN-1:0]        immNext;
	logic                          useImmNext;
	logic                          writesReg;

	function automatic rvPkg::aluOp_t mapAluOp(input logic [2:0] f3, input logic alt);
		rvPkg::aluOp_t op;
		case (f3)
			3'd0: op = alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
			3'd1: op = rvPkg::ALU_SLL;
			3'd2: op = rvPkg::ALU_SLT;
			3'd3: op = rvPkg::ALU_SLTU;
			3'd4: op = rvPkg::ALU_XOR;
			3'd5: op = alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
			3'd6: op = rvPkg::ALU_OR;
			default: op = rvPkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = rvPkg::opcode_t'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	assign rd = instr_i[11:7];
	assign immI = {{(rvPkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};
	assign immS = {{(rvPkg::XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign immU = {instr_i[31:12], 12'b0};

	always_comb
	begin
		kindNext = rvPkg::EX_IDLE;
		aluOpNext = rvPkg::ALU_ADD;
		rs1Next = instr_i[19:15];
		immNext = immI;
		useImmNext = 1'b1;
		case (opcode)
			rvPkg::OPC_OP:
			begin
				kindNext = rvPkg::EX_REG_WRITE;
				aluOpNext = mapAluOp(funct3, instr_i[30]);
				useImmNext = 1'b0;
			end
			rvPkg::OPC_OP_IMM:
			begin
				kindNext = rvPkg::EX_REG_WRITE;
				aluOpNext = mapAluOp(funct3, funct3 == 3'd5 && instr_i[30]); // only srai
			end
			rvPkg::OPC_LOAD: kindNext = rvPkg::EX_MEM_READ_REG_WRITE;
			rvPkg::OPC_STORE:
			begin
				kindNext = rvPkg::EX_MEM_WRITE;
				immNext = immS;
			end
			rvPkg::OPC_LUI:
			begin
				kindNext = rvPkg::EX_REG_WRITE;
				rs1Next = '0; // x0 + imm
				immNext = immU;
			end
			default: kindNext = rvPkg::EX_IDLE;
		endcase
		writesReg = kindNext == rvPkg::EX_REG_WRITE || kindNext == rvPkg::EX_MEM_READ_REG_WRITE;
		if (!instrValid_i || (writesReg && rd == '0))
			kindNext = rvPkg::EX_IDLE; // x0 writes are dropped here
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			kind_o <= rvPkg::EX_IDLE;
		else
			kind_o <= kindNext;
	end

	always_ff @(posedge clk)
	begin
		aluOp_o <= aluOpNext;
		rs1_o <= rs1Next;
		rs2_o <= instr_i[24:20];
		rd_o <= rd;
		imm_o <= immNext;
		useImm_o <= useImmNext;
	end

	validFollowsStrobe: assert property (@(posedge clk) disable iff (reset)
		kind_o != rvPkg::EX_IDLE |-> $past(instrValid_i))
		else $error("execute class set without an instruction strobe");

endmodule

//--- rtl/execStage.sv
module execStage (
	input  logic                          clk,
	input  logic                          reset,
	input  rvPkg::execKind_t              kind_i,
	input  rvPkg::aluOp_t                 aluOp_i,
	input  logic [rvPkg::REG_NUM_W-1:0]   rs1_i,
	input  logic [rvPkg::REG_NUM_W-1:0]   rs2_i,
	input  logic [rvPkg::REG_NUM_W-1:0]   rd_i,
	input  logic [rvPkg::XLEN-1:0]        imm_i,
	input  logic                          useImm_i,
	input  logic [rvPkg::XLEN-1:0]        rs1Data_i,
	input  logic [rvPkg::XLEN-1:0]        rs2Data_i,
	output logic [rvPkg::MEM_ADDR_W-1:0]  memAddr_o,
	output logic                          memWriteEn_o,
	output logic [rvPkg::XLEN-1:0]        memWriteData_o,
	input  logic [rvPkg::XLEN-1:0]        memReadData_i,
	output logic                          wbValid_o,
	output logic [rvPkg::REG_NUM_W-1:0]   wbNum_o,
	output logic [rvPkg::XLEN-1:0]        wbData_o
);

	logic [rvPkg::XLEN-1:0] rs1Val;
	logic [rvPkg::XLEN-1:0] rs2Val;
	logic [rvPkg::XLEN-1:0] aluB;
	logic [rvPkg::XLEN-1:0] aluResult;
	logic                   fwdRs1;
	logic                   fwdRs2;
	logic                   isLoad;
	logic                   writesReg;

	// the writeback stage is the only result not yet in the register file
	assign fwdRs1 = wbValid_o && wbNum_o == rs1_i;
	assign fwdRs2 = wbValid_o && wbNum_o == rs2_i;
	assign rs1Val = fwdRs1 ? wbData_o : rs1Data_i;
	assign rs2Val = fwdRs2 ? wbData_o : rs2Data_i;
	assign aluB = useImm_i ? imm_i : rs2Val;

	alu alu_inst (
		.a_i      (rs1Val),
		.b_i      (aluB),
		.op_i     (aluOp_i),
		.result_o (aluResult)
	);

	assign isLoad = kind_i == rvPkg::EX_MEM_READ_REG_WRITE;
	assign writesReg = kind_i == rvPkg::EX_REG_WRITE || isLoad;

	assign memAddr_o = aluResult[rvPkg::MEM_ADDR_W+1:2]; // word index
	assign memWriteEn_o = kind_i == rvPkg::EX_MEM_WRITE;
	assign memWriteData_o = rs2Val; // forwarded store data

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			wbValid_o <= 1'b0;
		else
			wbValid_o <= writesReg;
	end

	always_ff @(posedge clk)
	begin
		wbNum_o <= rd_i;
		wbData_o <= isLoad ? memReadData_i : aluResult;
	end

endmodule

//--- rtl/rvCore.sv
module rvCore (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          instrValid_i,
	input  logic [rvPkg::XLEN-1:0]        instr_i,
	input  logic [rvPkg::REG_NUM_W-1:0]   watchNum_i,
	output logic [rvPkg::XLEN-1:0]        watchData_o,
	output logic                          wbValid_o,
	output logic [rvPkg::REG_NUM_W-1:0]   wbNum_o,
	output logic [rvPkg::XLEN-1:0]        wbData_o
);

	rvPkg::execKind_t              kind;
	rvPkg::aluOp_t                 aluOp;
	logic [rvPkg::REG_NUM_W-1:0]   rs1, rs2, rd;
	logic [rvPkg::XLEN-1:0]        imm;
	logic                          useImm;
	logic [rvPkg::XLEN-1:0]        rs1Data, rs2Data;
	logic [rvPkg::MEM_ADDR_W-1:0]  memAddr;
	logic                          memWriteEn;
	logic [rvPkg::XLEN-1:0]        memWriteData, memReadData;

	instrDecoder instrDecoder_inst (
		.clk          (clk),
		.reset        (reset),
		.instrValid_i (instrValid_i),
		.instr_i      (instr_i),
		.kind_o       (kind),
		.aluOp_o      (aluOp),
		.rs1_o        (rs1),
		.rs2_o        (rs2),
		.rd_o         (rd),
		.imm_o        (imm),
		.useImm_o     (useImm)
	);

	regFile regFile_inst (
		.clk         (clk),
		.reset       (reset),
		.rs1_i       (rs1),
		.rs2_i       (rs2),
		.rs1Data_o   (rs1Data),
		.rs2Data_o   (rs2Data),
		.writeEn_i   (wbValid_o), // writeback feeds the write port
		.writeNum_i  (wbNum_o),
		.writeData_i (wbData_o),
		.watchNum_i  (watchNum_i),
		.watchData_o (watchData_o)
	);

	execStage execStage_inst (
		.clk            (clk),
		.reset          (reset),
		.kind_i         (kind),
		.aluOp_i        (aluOp),
		.rs1_i          (rs1),
		.rs2_i          (rs2),
		.rd_i           (rd),
		.imm_i          (imm),
		.useImm_i       (useImm),
		.rs1Data_i      (rs1Data),
		.rs2Data_i      (rs2Data),
		.memAddr_o      (memAddr),
		.memWriteEn_o   (memWriteEn),
		.memWriteData_o (memWriteData),
		.memReadData_i  (memReadData),
		.wbValid_o      (wbValid_o),
		.wbNum_o        (wbNum_o),
		.wbData_o       (wbData_o)
	);

	dataMem #(
		.DEPTH  (rvPkg::MEM_WORDS),
		.ADDR_W (rvPkg::MEM_ADDR_W),
		.DATA_W (rvPkg::XLEN)
	) dataMem_inst (
		.clk         (clk),
		.addr_i      (memAddr),
		.writeEn_i   (memWriteEn),
		.writeData_i (memWriteData),
		.readData_o  (memReadData)
	);

endmodule

//--- test/coreTb.sv
module coreTb;

	timeunit 1ns;
	timeprecision 1ps;

	logic                          clk;
	logic                          reset;
	logic                          instrValid;
	logic [rvPkg::XLEN-1:0]        instr;
	logic [rvPkg::REG_NUM_W-1:0]   watchNum;
	logic [rvPkg::XLEN-1:0]        watchData;
	logic                          wbValid;
	logic [rvPkg::REG_NUM_W-1:0]   wbNum;
	logic [rvPkg::XLEN-1:0]        wbData;

	logic [31:0] modelReg [32];
	logic [31:0] modelMem [1024];
	logic [4:0]  expNum [$];
	logic [31:0] expData [$];
	int          expCycle [$];
	int          cycleCount;
	int          errorCount;
	int          checkCount;

	rvCore rvCore_inst (
		.clk          (clk),
		.reset        (reset),
		.instrValid_i (instrValid),
		.instr_i      (instr),
		.watchNum_i   (watchNum),
		.watchData_o  (watchData),
		.wbValid_o    (wbValid),
		.wbNum_o      (wbNum),
		.wbData_o     (wbData)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	// every strobe must match the oldest outstanding expectation
	always @(negedge clk)
	begin
		if (!reset && wbValid)
		begin
			if (expNum.size() == 0)
			begin
				$display("error at %0t: writeback strobe for x%0d that no instruction expects",
					$time, wbNum);
				errorCount++;
			end
			else
			begin
				compareValue("wbNum_o", {27'b0, expNum[0]}, {27'b0, wbNum});
				compareValue("wbData_o", expData[0], wbData);
				compareValue("writeback cycle", expCycle[0], cycleCount);
				void'(expNum.pop_front());
				void'(expData.pop_front());
				void'(expCycle.pop_front());
			end
		end
	end

	function automatic logic [31:0] randWord();
		return $urandom();
	endfunction

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rvPkg::OPC_OP};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, rvPkg::OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] encLoad(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [4:0] rd);
		return {imm, rs1, 3'd2, rd, rvPkg::OPC_LOAD}; // lw
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], rvPkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, rvPkg::OPC_LUI};
	endfunction

	// integer semantics straight from the ISA
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $signed(a) >>> b[4:0] : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// drive one instruction and update the model in program order
	task automatic issue(input logic [31:0] word);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] res;
		logic        writes;
		@(posedge clk);
		#1;
		instrValid = 1'b1;
		instr = word;
		rd = word[11:7];
		f3 = word[14:12];
		a = modelReg[word[19:15]];
		b = modelReg[word[24:20]];
		immI = {{20{word[31]}}, word[31:20]};
		immS = {{20{word[31]}}, word[31:25], word[11:7]};
		res = '0;
		writes = 1'b0;
		case (word[6:0])
			rvPkg::OPC_OP:
			begin
				res = aluRef(f3, word[30], a, b);
				writes = 1'b1;
			end
			rvPkg::OPC_OP_IMM:
			begin
				res = aluRef(f3, f3 == 3'd5 && word[30], a, immI);
				writes = 1'b1;
			end
			rvPkg::OPC_LUI:
			begin
				res = {word[31:12], 12'b0};
				writes = 1'b1;
			end
			rvPkg::OPC_LOAD:
			begin
				res = modelMem[(a + immI) >> 2 & 32'h3ff]; // word index
				writes = 1'b1;
			end
			rvPkg::OPC_STORE: modelMem[(a + immS) >> 2 & 32'h3ff] = b;
			default: ;
		endcase
		if (writes && rd != 5'd0)
		begin
			modelReg[rd] = res;
			expNum.push_back(rd);
			expData.push_back(res);
			expCycle.push_back(cycleCount + 2); // fixed two-cycle latency
		end
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			instrValid = 1'b0;
		end
	endtask

	task automatic waitWriteback();
		int waited;
		waited = 0;
		idle(1);
		while (expNum.size() > 0 && waited < 10)
		begin
			idle(1);
			waited++;
		end
		if (expNum.size() > 0)
		begin
			$display("timeout at %0t: no writeback strobe came for x%0d", $time, expNum[0]);
			errorCount++;
			expNum.delete();
			expData.delete();
			expCycle.delete();
		end
	endtask

	task automatic checkWatch(input logic [4:0] num, input logic [31:0] expected);
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		watchNum = num;
		@(negedge clk);
		compareValue($sformatf("watchData_o[x%0d]", num), expected, watchData);
	endtask

	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		logic [19:0] upper;
		upper = value[31:12] + {19'b0, value[11]}; // addi sign-extends the low part
		issue(encU(upper, rd));
		issue(encI(value[11:0], rd, 3'd0, rd));
	endtask

	task automatic testReset();
		for (int i = 0; i < 32; i++)
			checkWatch(i[4:0], 32'h0);
		idle(3);
	endtask

	task automatic testConstants();
		logic [31:0] values [4];
		values = '{32'h12345678, 32'hfffff800, 32'h80000fff, 32'h000007ff};
		for (int i = 0; i < 4; i++)
		begin
			loadConst(5'(i + 1), values[i]);
			waitWriteback();
			checkWatch(5'(i + 1), values[i]);
		end
	endtask

	task automatic testAluChain();
		logic [2:0]  opF3 [10];
		logic        opAlt [10];
		logic [31:0] r;
		logic [11:0] imm;
		opF3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		opAlt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
		loadConst(5'd3, randWord());
		for (int k = 0; k < 10; k++)
		begin
			r = randWord();
			issue(encI(r[11:0], 5'd3, 3'd0, 5'd7)); // x3 forwarded
			issue(encR({1'b0, opAlt[k], 5'b0}, 5'd7, 5'd3, opF3[k], 5'd3)); // x7 forwarded
			r = randWord();
			if (opF3[k] == 3'd1 || opF3[k] == 3'd5)
				imm = {1'b0, opAlt[k], 5'b0, r[4:0]};
			else
				imm = r[11:0];
			issue(encI(imm, 5'd3, opF3[k], 5'd3));
		end
		waitWriteback();
		checkWatch(5'd3, modelReg[3]);
	endtask

	task automatic testZeroDest();
		issue(encR(7'b0, 5'd2, 5'd1, 3'd0, 5'd0));
		issue(encI(12'h123, 5'd1, 3'd0, 5'd0));
		issue(encU(20'habcde, 5'd0));
		issue({20'h12345, 5'd5, 7'b1111111}); // no such opcode
		idle(4);
		checkWatch(5'd0, 32'h0);
		checkWatch(5'd5, modelReg[5]);
	endtask

	task automatic testMemory();
		logic [31:0] r;
		logic [7:0]  offs [4];
		loadConst(5'd8, 32'h100);
		loadConst(5'd11, randWord());
		issue(encS(12'd8, 5'd11, 5'd8));
		issue(encLoad(12'd8, 5'd8, 5'd9)); // load right after the store
		issue(encR(7'b0, 5'd9, 5'd9, 3'd0, 5'd10));
		waitWriteback();
		checkWatch(5'd10, modelReg[10]);
		for (int i = 0; i < 4; i++)
		begin
			r = randWord();
			offs[i] = r[7:0];
			loadConst(5'd11, randWord());
			issue(encS({2'b0, offs[i], 2'b0}, 5'd11, 5'd8));
		end
		for (int i = 3; i >= 0; i--)
		begin
			issue(encLoad({2'b0, offs[i], 2'b0}, 5'd8, 5'd12));
			issue(encR(7'b0, 5'd12, 5'd12, 3'd0, 5'd13));
		end
		waitWriteback();
	endtask

	task automatic testSpacing();
		logic [31:0] r;
		for (int i = 0; i < 6; i++)
		begin
			r = randWord();
			issue(encI(r[11:0], 5'd3, 3'd0, 5'd14));
			idle(int'(r[13:12]) + 1);
		end
		waitWriteback();
		checkWatch(5'd14, modelReg[14]);
	endtask

	initial
	begin
		void'($urandom(53));
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		watchNum = '0;
		cycleCount = 0;
		errorCount = 0;
		checkCount = 0;
		for (int i = 0; i < 32; i++)
			modelReg[i] = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		testReset();
		testConstants();
		testAluChain();
		testZeroDest();
		testMemory();
		testSpacing();
		idle(4);
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- src.f
rtl/rvPkg.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/regFile.sv
rtl/instrDecoder.sv
rtl/execStage.sv
rtl/rvCore.sv
test/coreTb.sv

//--- Makefile
# Verilator simulation of the RV32I core testbench

TOP ?= coreTb
SRC_LIST ?= src.f
VERILATOR_FLAGS ?= --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	verilator $(VERILATOR_FLAGS) --binary --top-module $(TOP) -f $(SRC_LIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
